// File: rvBnnPkg.sv
package rvBnnPkg;

    localparam int DataWidth        = 32;                          // Register and instruction width
    localparam int RegAddrWidth     = 5;                           // Register index width
    localparam int PopcntGroupWidth = 4;                           // Bits per first-level group
    localparam int PopcntGroups     = DataWidth / PopcntGroupWidth; // First-level group count
    localparam int CountWidth       = $clog2(DataWidth + 1);       // Full popcount width, 0..32

    // Major opcodes
    localparam logic [6:0] OpcOp      = 7'b0110011;                // Register-register ALU
    localparam logic [6:0] OpcOpImm   = 7'b0010011;                // Register-immediate ALU
    localparam logic [6:0] OpcLui     = 7'b0110111;                // Load upper immediate
    localparam logic [6:0] OpcCustom0 = 7'b0001011;                // BNN extension

    // Integer funct3 codes, shared by OP and OP-IMM
    localparam logic [2:0] F3AddSub = 3'b000;
    localparam logic [2:0] F3Sll    = 3'b001;
    localparam logic [2:0] F3Xor    = 3'b100;
    localparam logic [2:0] F3Srl    = 3'b101;
    localparam logic [2:0] F3Or     = 3'b110;
    localparam logic [2:0] F3And    = 3'b111;

    // Custom-0 funct3 codes
    localparam logic [2:0] F3Popcnt = 3'b000;                      // R-type, funct7 zero
    localparam logic [2:0] F3Act    = 3'b001;                      // R-type, funct7 zero
    localparam logic [2:0] F3SetMs  = 3'b010;                      // I-type
    localparam logic [2:0] F3SetAt  = 3'b011;                      // I-type

    localparam logic [6:0] F7Base = 7'b0000000;
    localparam logic [6:0] F7Sub  = 7'b0100000;

    localparam logic [DataWidth-1:0] NopInstr = 32'h0000_0013;     // ADDI x0, x0, 0

    typedef enum logic [3:0] {
        ExNop, ExAdd, ExSub, ExAnd, ExOr, ExXor, ExSll, ExSrl,
        ExLui, ExPopcnt, ExAct, ExSetSize, ExSetThresh
    } exOp_t;

    // Count of one group, 0..4
    typedef logic [$clog2(PopcntGroupWidth + 1)-1:0] partialCount_t;

endpackage

// File: rvBnnBus.sv
interface rvBnnBus;

    import rvBnnPkg::*;

    logic                    valid;       // Real instruction in execute
    exOp_t                   op;          // Execute operation
    logic                    useImm;      // Operand B from imm
    logic [RegAddrWidth-1:0] rs1;         // Source indices for forwarding
    logic [RegAddrWidth-1:0] rs2;
    logic [RegAddrWidth-1:0] rd;          // Destination, nonzero when op writes
    logic [DataWidth-1:0]    rs1Data;     // Register file values read in decode
    logic [DataWidth-1:0]    rs2Data;
    logic [DataWidth-1:0]    imm;         // Extended immediate

    modport decode (
        output valid, op, useImm,
        output rs1, rs2, rd,
        output rs1Data, rs2Data, imm
    );

    modport execute (
        input valid, op, useImm,
        input rs1, rs2, rd,
        input rs1Data, rs2Data, imm
    );

endinterface

// File: fetchStage.sv
module fetchStage (
    input  logic                           clk,
    input  logic                           reset,
    input  logic [rvBnnPkg::DataWidth-1:0] instrF,
    output logic [rvBnnPkg::DataWidth-1:0] pcF,
    output logic [rvBnnPkg::DataWidth-1:0] instrD
);

    import rvBnnPkg::*;

    // No branches, so the PC only ever steps forward
    always_ff @(posedge clk) begin
        if (reset) begin
            pcF <= '0;                    // Start of program
        end else begin
            pcF <= pcF + DataWidth'(4);   // Next word
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            instrD <= NopInstr;           // Decode sees a no-op
        end else begin
            instrD <= instrF;             // Fetch/decode register
        end
    end

endmodule

// File: registerFile.sv
module registerFile (
    input  logic                              clk,
    input  logic                              reset,
    input  logic [rvBnnPkg::RegAddrWidth-1:0] readAddr1,
    input  logic [rvBnnPkg::RegAddrWidth-1:0] readAddr2,
    output logic [rvBnnPkg::DataWidth-1:0]    readData1,
    output logic [rvBnnPkg::DataWidth-1:0]    readData2,
    input  logic                              writeEn,
    input  logic [rvBnnPkg::RegAddrWidth-1:0] writeAddr,
    input  logic [rvBnnPkg::DataWidth-1:0]    writeData
);

    import rvBnnPkg::*;

    logic [DataWidth-1:0] regs [1:2**RegAddrWidth-1];   // x1..x31, x0 is not stored

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 1; i < 2**RegAddrWidth; i++) begin
                regs[i] <= '0;                          // Architectural state starts at zero
            end
        end else if (writeEn && writeAddr != '0) begin
            regs[writeAddr] <= writeData;
        end
    end

    // Write-through so decode sees a value committed in the same cycle
    always_comb begin
        if (readAddr1 == '0) readData1 = '0;
        else if (writeEn && writeAddr == readAddr1) readData1 = writeData;
        else readData1 = regs[readAddr1];

        if (readAddr2 == '0) readData2 = '0;
        else if (writeEn && writeAddr == readAddr2) readData2 = writeData;
        else readData2 = regs[readAddr2];
    end

    // Decode turns rd = x0 writes into no-ops, so none reach here
    noWriteX0: assert property (@(posedge clk) disable iff (reset) writeEn |-> writeAddr != '0)
        else $error("write to x0 reached the register file");

endmodule

// File: decodeStage.sv
module decodeStage (
    input  logic                              clk,
    input  logic                              reset,
    input  logic [rvBnnPkg::DataWidth-1:0]    instrD,
    input  logic                              wbWe,
    input  logic [rvBnnPkg::RegAddrWidth-1:0] wbAddr,
    input  logic [rvBnnPkg::DataWidth-1:0]    wbData,
    rvBnnBus.decode                           bus
);

    import rvBnnPkg::*;

    logic [6:0]              opcode;
    logic [2:0]              funct3;
    logic [6:0]              funct7;
    logic [RegAddrWidth-1:0] rs1D, rs2D, rdD;
    logic [DataWidth-1:0]    immI, immU, immD;
    logic [DataWidth-1:0]    rs1DataD, rs2DataD;
    exOp_t                   rawOp;         // Operation before the x0 check
    exOp_t                   opD;
    logic                    useImmD;
    logic                    writesRd;
    logic                    validD;

    assign opcode = instrD[6:0];
    assign funct3 = instrD[14:12];
    assign funct7 = instrD[31:25];
    assign rdD    = instrD[11:7];
    assign rs1D   = instrD[19:15];
    assign rs2D   = instrD[24:20];

    assign immI = {{(DataWidth-12){instrD[31]}}, instrD[31:20]};   // Sign-extended I-format
    assign immU = {instrD[31:12], 12'b0};                         // U-format, low bits zero
    assign immD = (opcode == OpcLui) ? immU : immI;

    always_comb begin
        rawOp   = ExNop;                                // Undefined encodings fall through
        useImmD = 1'b0;
        case (opcode)
            OpcOp: begin
                if (funct7 == F7Base) begin
                    case (funct3)
                        F3AddSub: rawOp = ExAdd;
                        F3Sll:    rawOp = ExSll;
                        F3Xor:    rawOp = ExXor;
                        F3Srl:    rawOp = ExSrl;
                        F3Or:     rawOp = ExOr;
                        F3And:    rawOp = ExAnd;
                        default:  rawOp = ExNop;
                    endcase
                end else if (funct7 == F7Sub && funct3 == F3AddSub) begin
                    rawOp = ExSub;
                end
            end
            OpcOpImm: begin
                useImmD = 1'b1;
                case (funct3)
                    F3AddSub: rawOp = ExAdd;            // ADDI
                    F3Xor:    rawOp = ExXor;            // XORI
                    F3Or:     rawOp = ExOr;             // ORI
                    F3And:    rawOp = ExAnd;            // ANDI
                    default:  rawOp = ExNop;            // Immediate shifts not supported
                endcase
            end
            OpcLui: begin
                rawOp   = ExLui;
                useImmD = 1'b1;
            end
            OpcCustom0: begin
                case (funct3)
                    F3Popcnt: rawOp = (funct7 == F7Base) ? ExPopcnt : ExNop;
                    F3Act:    rawOp = (funct7 == F7Base) ? ExAct : ExNop;
                    F3SetMs:  rawOp = ExSetSize;
                    F3SetAt:  rawOp = ExSetThresh;
                    default:  rawOp = ExNop;
                endcase
                useImmD = (funct3 == F3SetMs) || (funct3 == F3SetAt);
            end
            default: rawOp = ExNop;
        endcase
    end

    // Writes to x0 vanish here, later stages never look at rd
    assign writesRd = !(rawOp inside {ExNop, ExSetSize, ExSetThresh});
    assign opD      = (writesRd && rdD == '0) ? ExNop : rawOp;
    assign validD   = (opD != ExNop);

    registerFile regFile (
        .clk       (clk),
        .reset     (reset),
        .readAddr1 (rs1D),
        .readAddr2 (rs2D),
        .readData1 (rs1DataD),
        .readData2 (rs2DataD),
        .writeEn   (wbWe),
        .writeAddr (wbAddr),
        .writeData (wbData)
    );

    // Decode/execute register
    always_ff @(posedge clk) begin
        if (reset) begin
            bus.valid <= 1'b0;
            bus.op    <= ExNop;
        end else begin
            bus.valid <= validD;
            bus.op    <= opD;
        end
    end

    always_ff @(posedge clk) begin
        bus.useImm  <= useImmD;
        bus.rs1     <= rs1D;
        bus.rs2     <= rs2D;
        bus.rd      <= rdD;
        bus.rs1Data <= rs1DataD;
        bus.rs2Data <= rs2DataD;
        bus.imm     <= immD;
    end

endmodule

// File: bnnUnit.sv
module bnnUnit (
    input  logic                           clk,
    input  logic                           reset,
    input  rvBnnPkg::exOp_t                op,
    input  logic [rvBnnPkg::DataWidth-1:0] opA,
    input  logic [rvBnnPkg::DataWidth-1:0] opB,
    input  logic [rvBnnPkg::DataWidth-1:0] imm,
    output rvBnnPkg::partialCount_t        countsE [rvBnnPkg::PopcntGroups],
    input  rvBnnPkg::partialCount_t        countsW [rvBnnPkg::PopcntGroups],
    input  logic                           activateW,
    output logic [rvBnnPkg::DataWidth-1:0] bnnResult
);

    import rvBnnPkg::*;

    logic [CountWidth-1:0] matrixSize;      // 1..32 valid bits
    logic [DataWidth-1:0]  threshold;       // Activation threshold
    logic [DataWidth-1:0]  sizeMask;
    logic [DataWidth-1:0]  matchBits;       // Masked XNOR
    logic                  bnnActive;
    logic [CountWidth-1:0] countSum;

    // Configuration, visible to the next instruction in execute
    always_ff @(posedge clk) begin
        if (reset) begin
            matrixSize <= CountWidth'(DataWidth);
            threshold  <= '0;
        end else if (op == ExSetSize) begin
            if (imm == '0 || imm > DataWidth) matrixSize <= CountWidth'(DataWidth);
            else matrixSize <= imm[CountWidth-1:0];
        end else if (op == ExSetThresh) begin
            threshold <= imm;
        end
    end

    always_comb begin
        for (int i = 0; i < DataWidth; i++) begin
            sizeMask[i] = (i < matrixSize);          // Drop bits at and above the size
        end
    end

    assign bnnActive = (op == ExPopcnt) || (op == ExAct);
    assign matchBits = ~(opA ^ opB) & sizeMask;

    // First level in execute, counts stay zero off the BNN path
    always_comb begin
        for (int g = 0; g < PopcntGroups; g++) begin
            countsE[g] = '0;
            if (bnnActive) begin
                for (int b = 0; b < PopcntGroupWidth; b++) begin
                    countsE[g] = countsE[g]
                               + partialCount_t'(matchBits[g*PopcntGroupWidth + b]);
                end
            end
        end
    end

    // Second level in writeback
    always_comb begin
        countSum = '0;
        for (int g = 0; g < PopcntGroups; g++) begin
            countSum = countSum + CountWidth'(countsW[g]);
        end
    end

    assign bnnResult = activateW ? DataWidth'(DataWidth'(countSum) >= threshold)
                                 : DataWidth'(countSum);

    // The count in writeback was masked by the size still held now
    sumInRange: assert property (@(posedge clk) disable iff (reset) countSum <= matrixSize)
        else $error("popcount %0d exceeds matrix size %0d", countSum, matrixSize);

endmodule

// File: executeStage.sv
module executeStage (
    input  logic                              clk,
    input  logic                              reset,
    rvBnnBus.execute                          bus,
    output logic                              wbWe,
    output logic [rvBnnPkg::RegAddrWidth-1:0] wbAddr,
    output logic [rvBnnPkg::DataWidth-1:0]    wbData
);

    import rvBnnPkg::*;

    logic [DataWidth-1:0] opA, opB;          // Forwarded operands
    logic [DataWidth-1:0] aluB;              // Register or immediate
    logic [DataWidth-1:0] aluResultE;
    logic [DataWidth-1:0] aluResultW;
    logic [DataWidth-1:0] bnnResult;
    exOp_t                opE;               // Operation gated by valid
    logic                 writesE;
    logic                 bnnPathE, bnnPathW;
    logic                 activateE, activateW;
    partialCount_t        countsE [PopcntGroups];
    partialCount_t        countsW [PopcntGroups];

    // Writeback forwarding, x0 never matches since wbAddr is nonzero on wbWe
    assign opA = (wbWe && wbAddr == bus.rs1) ? wbData : bus.rs1Data;
    assign opB = (wbWe && wbAddr == bus.rs2) ? wbData : bus.rs2Data;

    assign aluB = bus.useImm ? bus.imm : opB;
    assign opE  = bus.valid ? bus.op : ExNop;

    always_comb begin
        case (opE)
            ExAdd:   aluResultE = opA + aluB;
            ExSub:   aluResultE = opA - aluB;
            ExAnd:   aluResultE = opA & aluB;
            ExOr:    aluResultE = opA | aluB;
            ExXor:   aluResultE = opA ^ aluB;
            ExSll:   aluResultE = opA << aluB[4:0];     // Low 5 bits only
            ExSrl:   aluResultE = opA >> aluB[4:0];
            ExLui:   aluResultE = bus.imm;
            default: aluResultE = '0;
        endcase
    end

    assign writesE   = !(opE inside {ExNop, ExSetSize, ExSetThresh});
    assign bnnPathE  = (opE == ExPopcnt) || (opE == ExAct);
    assign activateE = (opE == ExAct);

    bnnUnit bnn (
        .clk       (clk),
        .reset     (reset),
        .op        (opE),
        .opA       (opA),
        .opB       (opB),
        .imm       (bus.imm),
        .countsE   (countsE),
        .countsW   (countsW),
        .activateW (activateW),
        .bnnResult (bnnResult)
    );

    // Execute/writeback register
    always_ff @(posedge clk) begin
        if (reset) begin
            wbWe <= 1'b0;
        end else begin
            wbWe <= writesE;
        end
    end

    always_ff @(posedge clk) begin
        wbAddr     <= bus.rd;
        aluResultW <= aluResultE;
        bnnPathW   <= bnnPathE;
        activateW  <= activateE;
        countsW    <= countsE;                          // Split popcount crosses here
    end

    assign wbData = bnnPathW ? bnnResult : aluResultW;  // Path select in writeback

    wbAddrNonzero: assert property (@(posedge clk) disable iff (reset) wbWe |-> wbAddr != '0)
        else $error("writeback enabled for x0");

endmodule

// File: rvBnnCore.sv
module rvBnnCore (
    input  logic                              clk,
    input  logic                              reset,
    input  logic [rvBnnPkg::DataWidth-1:0]    instrF,
    output logic [rvBnnPkg::DataWidth-1:0]    pcF,
    output logic                              regWe,
    output logic [rvBnnPkg::RegAddrWidth-1:0] regAddr,
    output logic [rvBnnPkg::DataWidth-1:0]    regData
);

    import rvBnnPkg::*;

    logic [DataWidth-1:0] instrD;            // Fetch to decode

    rvBnnBus bus ();                         // Decode to execute

    fetchStage fetch (
        .clk    (clk),
        .reset  (reset),
        .instrF (instrF),
        .pcF    (pcF),
        .instrD (instrD)
    );

    decodeStage decode (
        .clk    (clk),
        .reset  (reset),
        .instrD (instrD),
        .wbWe   (regWe),                     // Writeback doubles as the commit port
        .wbAddr (regAddr),
        .wbData (regData),
        .bus    (bus.decode)
    );

    executeStage execute (
        .clk    (clk),
        .reset  (reset),
        .bus    (bus.execute),
        .wbWe   (regWe),
        .wbAddr (regAddr),
        .wbData (regData)
    );

endmodule

// File: tbRvBnnCore.sv
module tbRvBnnCore;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int          ProgLen     = 200;           // Program words
    localparam int          Seed        = 90857;
    localparam int          ResetCycles = 2;
    localparam int          RunTimeout  = 400;           // Falling edges for the whole run
    localparam logic [31:0] NopWord     = 32'h0000_0013; // ADDI x0, x0, 0
    localparam logic [31:0] LfsrMask    = 32'h8020_0003; // Taps 32, 22, 2, 1

    logic        clk;
    logic        reset;
    logic [31:0] instrF;
    logic [31:0] pcF;
    logic        regWe;
    logic [4:0]  regAddr;
    logic [31:0] regData;

    logic [31:0] lfsrState;
    logic [31:0] progMem [ProgLen];                      // Instruction memory image
    int          kind    [ProgLen];                      // 0..15 real kinds, 16..17 undefined
    logic [4:0]  rdSel   [ProgLen];
    logic [4:0]  rs1Sel  [ProgLen];
    logic [4:0]  rs2Sel  [ProgLen];
    logic [31:0] immVal  [ProgLen];
    logic [4:0]  expAddr [$];                            // Expected commits, in order
    logic [31:0] expData [$];
    logic [31:0] expPc   [$];
    logic [31:0] servedPc    [3];                        // Addresses served 1, 2, 3 edges ago
    logic        servedValid [3];
    int          checkErrors, otherErrors, commits, expTotal;

    rvBnnCore UUT (
        .clk     (clk),
        .reset   (reset),
        .instrF  (instrF),
        .pcF     (pcF),
        .regWe   (regWe),
        .regAddr (regAddr),
        .regData (regData)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Galois LFSR, one step per bit taken
    function automatic logic [31:0] randBits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r = {r[30:0], lfsrState[0]};
            lfsrState = lfsrState[0] ? ((lfsrState >> 1) ^ LfsrMask) : (lfsrState >> 1);
        end
        return r;
    endfunction

    function automatic logic [31:0] encode(input int k, input logic [4:0] rd,
                                           input logic [4:0] rs1, input logic [4:0] rs2,
                                           input logic [31:0] imm);
        logic [31:0] w;
        case (k)
            0:  w = {7'h00, rs2, rs1, 3'b000, rd, 7'b0110011};        // ADD
            1:  w = {7'h20, rs2, rs1, 3'b000, rd, 7'b0110011};        // SUB
            2:  w = {7'h00, rs2, rs1, 3'b111, rd, 7'b0110011};        // AND
            3:  w = {7'h00, rs2, rs1, 3'b110, rd, 7'b0110011};        // OR
            4:  w = {7'h00, rs2, rs1, 3'b100, rd, 7'b0110011};        // XOR
            5:  w = {7'h00, rs2, rs1, 3'b001, rd, 7'b0110011};        // SLL
            6:  w = {7'h00, rs2, rs1, 3'b101, rd, 7'b0110011};        // SRL
            7:  w = {imm[11:0], rs1, 3'b000, rd, 7'b0010011};         // ADDI
            8:  w = {imm[11:0], rs1, 3'b111, rd, 7'b0010011};         // ANDI
            9:  w = {imm[11:0], rs1, 3'b110, rd, 7'b0010011};         // ORI
            10: w = {imm[11:0], rs1, 3'b100, rd, 7'b0010011};         // XORI
            11: w = {imm[19:0], rd, 7'b0110111};                      // LUI
            12: w = {7'h00, rs2, rs1, 3'b000, rd, 7'b0001011};        // POPCNT
            13: w = {7'h00, rs2, rs1, 3'b001, rd, 7'b0001011};        // ACT
            14: w = {imm[11:0], rs1, 3'b010, rd, 7'b0001011};         // SETMS
            15: w = {imm[11:0], rs1, 3'b011, rd, 7'b0001011};         // SETAT
            16: w = {imm[11:0], rs1, 3'b001, rd, 7'b0010011};         // SLLI, outside the subset
            default: w = {imm[11:0], rs1, 1'b1, imm[1:0], rd, 7'b0001011}; // Custom-0 funct3 1xx
        endcase
        return w;
    endfunction

    task automatic buildProgram();
        logic [4:0] lastRd;
        logic [4:0] prevRd;
        lastRd = 5'd1;
        prevRd = 5'd2;
        lfsrState = Seed;
        for (int i = 0; i < ProgLen; i++) begin
            kind[i]   = randBits(5) % 18;
            rdSel[i]  = 5'(randBits(3));                                 // x0 now and then
            rs1Sel[i] = randBits(1) ? lastRd : 5'(randBits(3));          // One apart
            rs2Sel[i] = randBits(1) ? prevRd : 5'(randBits(3));          // Two apart
            case (kind[i])
                11:      immVal[i] = randBits(20);
                14:      immVal[i] = randBits(6) % 41;                   // Sizes 0..40
                15:      immVal[i] = randBits(6) % 34;                   // Thresholds 0..33
                default: immVal[i] = randBits(12);
            endcase
            progMem[i] = encode(kind[i], rdSel[i], rs1Sel[i], rs2Sel[i], immVal[i]);
            if (rdSel[i] != 0) begin
                prevRd = lastRd;
                lastRd = rdSel[i];
            end
        end
    endtask

    // Sequential interpreter, builds the expected commit list
    task automatic runModel();
        logic [31:0] regs [8];
        logic [31:0] a, b, bi, res, thresh;
        logic        writes;
        int          size, count;
        for (int r = 0; r < 8; r++) regs[r] = '0;
        size   = 32;
        thresh = '0;
        for (int i = 0; i < ProgLen; i++) begin
            a      = regs[rs1Sel[i]];
            b      = regs[rs2Sel[i]];
            bi     = {{20{immVal[i][11]}}, immVal[i][11:0]};   // Sign-extended I immediate
            writes = 1'b1;
            res    = '0;
            count  = 0;
            for (int k = 0; k < size; k++) count += (a[k] == b[k]);
            case (kind[i])
                0:  res = a + b;
                1:  res = a - b;
                2:  res = a & b;
                3:  res = a | b;
                4:  res = a ^ b;
                5:  res = a << b[4:0];
                6:  res = a >> b[4:0];
                7:  res = a + bi;
                8:  res = a & bi;
                9:  res = a | bi;
                10: res = a ^ bi;
                11: res = {immVal[i][19:0], 12'b0};
                12: res = count;
                13: res = (count >= thresh) ? 32'd1 : 32'd0;
                14: begin
                    size   = (bi == 0 || bi > 32) ? 32 : bi;      // 0 and oversize mean 32
                    writes = 1'b0;
                end
                15: begin
                    thresh = bi;
                    writes = 1'b0;
                end
                default: writes = 1'b0;                           // Undefined, no commit
            endcase
            if (writes && rdSel[i] != 0) begin
                regs[rdSel[i]] = res;
                expAddr.push_back(rdSel[i]);
                expData.push_back(res);
                expPc.push_back(32'(i * 4));
            end
        end
        expTotal = expAddr.size();
    endtask

    task automatic reportMismatch(input string msg);
        checkErrors++;
        $display("CHECK FAILED at %0t: %s", $time, msg);
    endtask

    task automatic checkCommit();
        assert (expAddr.size() != 0) else begin
            otherErrors++;
            $display("Commit to x%0d at %0t came after all expected commits", regAddr, $time);
        end
        if (expAddr.size() != 0) begin
            assert (regAddr == expAddr[0]) else reportMismatch($sformatf(
                "commit %0d wrote x%0d, expected x%0d", commits, regAddr, expAddr[0]));
            assert (regData == expData[0]) else reportMismatch($sformatf(
                "commit %0d to x%0d gave %h, expected %h", commits, regAddr, regData, expData[0]));
            assert (servedValid[2] && servedPc[2] == expPc[0]) else reportMismatch($sformatf(
                "commit %0d for pc %h not 3 cycles after it was served", commits, expPc[0]));
            void'(expAddr.pop_front());
            void'(expData.pop_front());
            void'(expPc.pop_front());
        end
        commits++;
    endtask

    initial begin
        int          cycle;
        logic [31:0] lastPc;
        reset       = 1'b1;
        instrF      = NopWord;
        checkErrors = 0;
        otherErrors = 0;
        commits     = 0;
        cycle       = 0;
        lastPc      = '0;
        for (int s = 0; s < 3; s++) begin
            servedPc[s]    = '0;
            servedValid[s] = 1'b0;
        end
        buildProgram();
        runModel();
        do begin
            @(negedge clk);                                 // Outputs settled, inputs change here
            if (reset) begin
                assert (pcF == 0) else reportMismatch($sformatf("pcF %h during reset", pcF));
            end else begin
                assert (pcF == lastPc + 4) else reportMismatch($sformatf(
                    "pcF %h after %h, expected a step of 4", pcF, lastPc));
            end
            if (!servedValid[2]) begin
                assert (!regWe) else reportMismatch("regWe high with nothing in flight");
            end
            if (regWe) checkCommit();
            lastPc         = pcF;
            servedPc[2]    = servedPc[1];
            servedValid[2] = servedValid[1];
            servedPc[1]    = servedPc[0];
            servedValid[1] = servedValid[0];
            if (cycle + 1 >= ResetCycles) reset = 1'b0;     // Two rising edges in reset
            servedPc[0]    = pcF;
            servedValid[0] = !reset;                        // Sampled at the next rising edge
            instrF         = ((pcF >> 2) < ProgLen) ? progMem[pcF >> 2] : NopWord;
            cycle++;
        end while (pcF < ProgLen * 4 + 16 && cycle < RunTimeout);

        assert (pcF >= ProgLen * 4 + 16) else begin
            otherErrors++;
            $display("Timed out waiting for pcF to pass the end of the program");
        end
        assert (commits == expTotal) else begin
            otherErrors++;
            $display("Saw %0d commits but the model expected %0d", commits, expTotal);
        end

        $display("Errors: %0d value, %0d other (%0d commits checked)",
                 checkErrors, otherErrors, commits);
        if (checkErrors == 0 && otherErrors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

// File: rvBnnCore.f
rvBnnPkg.sv
rvBnnBus.sv
fetchStage.sv
registerFile.sv
decodeStage.sv
bnnUnit.sv
executeStage.sv
rvBnnCore.sv
tbRvBnnCore.sv

// File: Bender.yml
package:
  name: rvBnnCore

sources:
  - rvBnnPkg.sv
  - rvBnnBus.sv
  - fetchStage.sv
  - registerFile.sv
  - decodeStage.sv
  - bnnUnit.sv
  - executeStage.sv
  - rvBnnCore.sv
  - target: simulation
    files:
      - tbRvBnnCore.sv
